/* compile.f */
+incdir+include
design/axi_pkg.sv
design/axi_burst_addr.sv
design/ram_array.sv
design/axi_write_engine.sv
design/axi_read_engine.sv
design/axi_ram_top.sv
dv/axi_ram_asserts.sv
dv/axi_ram_tb.sv

/* design/axi_burst_addr.sv */
`timescale 1ns/1ps

module axi_burst_addr (
    input  axi_pkg::axi_addr_t addr,
    input  axi_pkg::axi_ax_t   cmd,
    output axi_pkg::axi_addr_t next_addr,
    output logic               illegal
);

    axi_pkg::axi_addr_t beat_bytes;
    axi_pkg::axi_addr_t incr_addr;
    axi_pkg::axi_addr_t wrap_mask;
    logic               wrap_len_ok;

    assign beat_bytes = axi_pkg::axi_addr_t'(1) << cmd.size;
    assign incr_addr  = addr + beat_bytes; // Rolls over at 4 KB

    // Window is (len+1) beats, mask keeps the offset inside it
    assign wrap_mask = ((axi_pkg::axi_addr_t'(cmd.len) + axi_pkg::axi_addr_t'(1)) << cmd.size)
                       - axi_pkg::axi_addr_t'(1);

    assign wrap_len_ok = (cmd.len == 8'd1) || (cmd.len == 8'd3) ||
                         (cmd.len == 8'd7) || (cmd.len == 8'd15);

    assign illegal = (cmd.size > axi_pkg::SIZE_4B) ||
                     ((cmd.burst == axi_pkg::BURST_WRAP) && !wrap_len_ok);

    always_comb begin
        case (cmd.burst)
            axi_pkg::BURST_INCR: next_addr = incr_addr;
            axi_pkg::BURST_WRAP: next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:             next_addr = addr; // FIXED
        endcase
    end

endmodule

/* design/axi_pkg.sv */
`include "axi_ram_macros.svh"

package axi_pkg;

    typedef logic [`AXI_ADDR_W-1:0]  axi_addr_t;
    typedef logic [`AXI_ID_W-1:0]    axi_id_t;
    typedef logic [`AXI_LEN_W-1:0]   axi_len_t;
    typedef logic [`AXI_DATA_W-1:0]  axi_data_t;
    typedef logic [`AXI_STRB_W-1:0]  axi_strb_t;
    typedef logic [`RAM_WORD_AW-1:0] ram_word_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // Bytes per beat as log2, anything above SIZE_4B is wider than the bus
    typedef enum logic [2:0] {
        SIZE_1B   = 3'd0,
        SIZE_2B   = 3'd1,
        SIZE_4B   = 3'd2,
        SIZE_8B   = 3'd3,
        SIZE_16B  = 3'd4,
        SIZE_32B  = 3'd5,
        SIZE_64B  = 3'd6,
        SIZE_128B = 3'd7
    } axi_size_e;

    // AW and AR share one layout
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_e  size;
        axi_burst_e burst;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_e resp;
    } axi_b_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_e resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        logic      en;
        ram_word_t addr;
        axi_data_t data;
        axi_strb_t be;
    } ram_wr_t;

endpackage

/* design/axi_ram_top.sv */
`timescale 1ns/1ps
`include "axi_ram_macros.svh"

module axi_ram_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             aw_valid,
    output logic             aw_ready,
    input  axi_pkg::axi_ax_t aw,
    input  logic             w_valid,
    output logic             w_ready,
    input  axi_pkg::axi_w_t  w,
    output logic             b_valid,
    input  logic             b_ready,
    output axi_pkg::axi_b_t  b,
    input  logic             ar_valid,
    output logic             ar_ready,
    input  axi_pkg::axi_ax_t ar,
    output logic             r_valid,
    input  logic             r_ready,
    output axi_pkg::axi_r_t  r
);

    axi_pkg::ram_wr_t        ram_wr;
    logic                    rd_en;
    logic [`RAM_WORD_AW-1:0] rd_addr;
    logic [`AXI_DATA_W-1:0]  rd_data;

    axi_write_engine wr_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ram_wr   (ram_wr)
    );

    axi_read_engine rd_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    ram_array ram_i (
        .clk     (clk),
        .ram_wr  (ram_wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* design/axi_read_engine.sv */
`timescale 1ns/1ps
`include "axi_ram_macros.svh"

module axi_read_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  axi_pkg::axi_ax_t        ar,
    output logic                    r_valid,
    input  logic                    r_ready,
    output axi_pkg::axi_r_t         r,
    output logic                    rd_en,
    output logic [`RAM_WORD_AW-1:0] rd_addr,
    input  logic [`AXI_DATA_W-1:0]  rd_data
);

    typedef enum logic {
        R_IDLE,
        R_BUSY
    } rd_state_e;

    rd_state_e              state;
    axi_pkg::axi_ax_t       cmd;
    axi_pkg::axi_ax_t       cur_cmd;
    axi_pkg::axi_addr_t     addr_q;
    axi_pkg::axi_addr_t     cur_addr;
    axi_pkg::axi_addr_t     next_addr;
    axi_pkg::axi_len_t      remain;
    axi_pkg::axi_len_t      ld_cnt;
    logic [`AXI_DATA_W-1:0] slot_data;
    logic                   slot_valid;
    logic                   slot_last;
    logic                   pend;     // rd_data holds a word not yet in the slot
    logic                   err_q;
    logic                   illegal;
    logic                   ar_hs;
    logic                   r_hs;
    logic                   load;
    logic                   issue;

    assign ar_ready = (state == R_IDLE);
    assign ar_hs    = ar_valid && ar_ready;
    assign r_hs     = r_valid && r_ready;

    // First beat is fetched straight off the AR channel
    assign cur_cmd  = ar_ready ? ar : cmd;
    assign cur_addr = ar_ready ? ar.addr : addr_q;

    axi_burst_addr addr_i (
        .addr      (cur_addr),
        .cmd       (cur_cmd),
        .next_addr (next_addr),
        .illegal   (illegal)
    );

    assign load  = pend && (!slot_valid || r_ready);
    assign issue = (state == R_BUSY) && (remain != '0) && (!pend || load);

    assign rd_en   = ar_hs || issue;
    assign rd_addr = cur_addr[`AXI_ADDR_W-1:2];

    assign r_valid = slot_valid;
    assign r.id    = cmd.id;
    assign r.data  = slot_data;
    assign r.resp  = err_q ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
    assign r.last  = slot_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= R_IDLE;
            remain     <= '0;
            ld_cnt     <= '0;
            pend       <= 1'b0;
            slot_valid <= 1'b0;
            slot_last  <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            if (ar_hs) begin
                state  <= R_BUSY;
                remain <= ar.len;
                ld_cnt <= '0;
                err_q  <= illegal;
            end else if (r_hs && slot_last) begin
                state <= R_IDLE;
            end
            if (issue)
                remain <= remain - 8'd1;
            pend <= rd_en || (pend && !load);
            if (load) begin
                slot_valid <= 1'b1;
                slot_last  <= (ld_cnt == cmd.len);
                ld_cnt     <= ld_cnt + 8'd1;
            end else if (r_hs) begin
                slot_valid <= 1'b0;
                slot_last  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs)
            cmd <= ar;
        if (rd_en)
            addr_q <= next_addr;
        if (load)
            slot_data <= err_q ? '0 : rd_data; // Zero data on SLVERR
    end

endmodule

/* design/axi_write_engine.sv */
`timescale 1ns/1ps
`include "axi_ram_macros.svh"

module axi_write_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             aw_valid,
    output logic             aw_ready,
    input  axi_pkg::axi_ax_t aw,
    input  logic             w_valid,
    output logic             w_ready,
    input  axi_pkg::axi_w_t  w,
    output logic             b_valid,
    input  logic             b_ready,
    output axi_pkg::axi_b_t  b,
    output axi_pkg::ram_wr_t ram_wr
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,
        W_RESP
    } wr_state_e;

    wr_state_e          state;
    axi_pkg::axi_ax_t   cmd;
    axi_pkg::axi_addr_t addr_q;
    axi_pkg::axi_addr_t next_addr;
    axi_pkg::axi_len_t  beat_cnt;
    logic               illegal;
    logic               aw_hs;
    logic               w_hs;

    axi_burst_addr addr_i (
        .addr      (addr_q),
        .cmd       (cmd),
        .next_addr (next_addr),
        .illegal   (illegal)
    );

    assign aw_ready = (state == W_IDLE);
    assign w_ready  = (state == W_DATA);
    assign b_valid  = (state == W_RESP);

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;

    // Strobed write lands on the same edge as the W transfer
    assign ram_wr.en   = w_hs && !illegal;
    assign ram_wr.addr = addr_q[`AXI_ADDR_W-1:2];
    assign ram_wr.data = w.data;
    assign ram_wr.be   = w.strb;

    assign b.id   = cmd.id;
    assign b.resp = illegal ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= W_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (aw_hs) begin
                        state    <= W_DATA;
                        beat_cnt <= '0;
                    end
                end
                W_DATA: begin
                    if (w_hs) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        if (beat_cnt == cmd.len)
                            state <= W_RESP; // Beat count ends the burst, not w.last
                    end
                end
                W_RESP: begin
                    if (b_ready)
                        state <= W_IDLE;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            cmd    <= aw;
            addr_q <= aw.addr;
        end else if (w_hs) begin
            addr_q <= next_addr;
        end
    end

endmodule

/* design/ram_array.sv */
`timescale 1ns/1ps
`include "axi_ram_macros.svh"

module ram_array (
    input  logic                    clk,
    input  axi_pkg::ram_wr_t        ram_wr,
    input  logic                    rd_en,
    input  logic [`RAM_WORD_AW-1:0] rd_addr,
    output logic [`AXI_DATA_W-1:0]  rd_data
);

    logic [`AXI_DATA_W-1:0] mem [0:(1 << `RAM_WORD_AW)-1];

    // Byte lane write
    always_ff @(posedge clk) begin
        if (ram_wr.en) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (ram_wr.be[i])
                    mem[ram_wr.addr][8*i +: 8] <= ram_wr.data[8*i +: 8];
            end
        end
    end

    // Registered read, sees the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

/* dv/axi_ram_asserts.sv */
`timescale 1ns/1ps

module axi_ram_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            aw_ready,
    input logic            b_valid,
    input logic            b_ready,
    input logic            r_valid,
    input logic            r_ready,
    input axi_pkg::axi_r_t r
);

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
                             b_valid && !b_ready |=> b_valid)
        else $error("b_valid dropped before b_ready");

    // Stalled R beat keeps valid and payload
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
                             r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("R channel changed while r_ready was low");

    aw_blocked: assert property (@(posedge clk) disable iff (!rst_n) b_valid |-> !aw_ready)
        else $error("aw_ready high during a write response");

    last_valid: assert property (@(posedge clk) disable iff (!rst_n) r.last |-> r_valid)
        else $error("r.last seen without r_valid");

endmodule

bind axi_ram_top axi_ram_asserts asserts_i (.*);

/* dv/axi_ram_tb.sv */
`timescale 1ns/1ps

module axi_ram_tb;

    localparam int TIMEOUT_CYCLES = 200;

    logic             clk;
    logic             rst_n;
    logic             aw_valid;
    logic             aw_ready;
    axi_pkg::axi_ax_t aw;
    logic             w_valid;
    logic             w_ready;
    axi_pkg::axi_w_t  w;
    logic             b_valid;
    logic             b_ready;
    axi_pkg::axi_b_t  b;
    logic             ar_valid;
    logic             ar_ready;
    axi_pkg::axi_ax_t ar;
    logic             r_valid;
    logic             r_ready;
    axi_pkg::axi_r_t  r;

    logic [7:0]  model [0:4095]; // Byte image of the memory
    logic [31:0] wdata [0:15];
    logic [3:0]  wstrb [0:15];
    int          seed = 61;

    axi_ram_top dut_i (.*);

    always #4 clk = ~clk;

    function automatic axi_pkg::axi_ax_t make_cmd(input logic [3:0] id,
                                                  input axi_pkg::axi_addr_t addr,
                                                  input logic [7:0] len,
                                                  input axi_pkg::axi_size_e size,
                                                  input axi_pkg::axi_burst_e burst);
        axi_pkg::axi_ax_t c;
        c.id    = id;
        c.addr  = addr;
        c.len   = len;
        c.size  = size;
        c.burst = burst;
        return c;
    endfunction

    // Wider than the bus, or a WRAP that is not 2, 4, 8 or 16 beats
    function automatic bit burst_illegal(input axi_pkg::axi_ax_t c);
        return (c.size > axi_pkg::SIZE_4B) ||
               ((c.burst == axi_pkg::BURST_WRAP) && !((int'(c.len) + 1) inside {2, 4, 8, 16}));
    endfunction

    function automatic axi_pkg::axi_addr_t next_beat_addr(input axi_pkg::axi_addr_t a,
                                                          input axi_pkg::axi_ax_t c);
        int nbytes;
        int win;
        int base;
        nbytes = 1 << c.size;
        win    = (int'(c.len) + 1) * nbytes;
        base   = (int'(a) / win) * win; // Window aligned to its own size
        case (c.burst)
            axi_pkg::BURST_INCR: return axi_pkg::axi_addr_t'((int'(a) + nbytes) % 4096);
            axi_pkg::BURST_WRAP: return axi_pkg::axi_addr_t'(base + (int'(a) - base + nbytes) % win);
            default:             return a;
        endcase
    endfunction

    function automatic axi_pkg::axi_data_t model_word(input axi_pkg::axi_addr_t a);
        axi_pkg::axi_addr_t base;
        base = {a[11:2], 2'b00};
        return {model[base + 12'd3], model[base + 12'd2], model[base + 12'd1], model[base]};
    endfunction

    task automatic stop_on_failure;
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic count_cycle(inout int cycles, input string what);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout while waiting for %s", what);
            stop_on_failure();
        end
    endtask

    // Beats come from wdata and wstrb
    task automatic write_burst(input axi_pkg::axi_ax_t cmd);
        axi_pkg::axi_addr_t addr;
        axi_pkg::axi_addr_t byte_addr;
        axi_pkg::axi_resp_e exp_resp;
        int                 cycles;
        int                 beat;
        int                 i;
        addr     = cmd.addr;
        exp_resp = burst_illegal(cmd) ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
        @(posedge clk);
        aw_valid <= 1'b1;
        aw       <= cmd;
        cycles = 0;
        @(negedge clk);
        while (!aw_ready) begin
            count_cycle(cycles, "aw_ready");
            @(negedge clk);
        end
        @(posedge clk);
        aw_valid <= 1'b0;
        for (beat = 0; beat <= int'(cmd.len); beat++) begin
            w_valid <= 1'b1;
            w.data  <= wdata[beat];
            w.strb  <= wstrb[beat];
            w.last  <= (beat == int'(cmd.len));
            cycles = 0;
            @(negedge clk);
            while (!w_ready) begin
                count_cycle(cycles, "w_ready");
                @(negedge clk);
            end
            if (!burst_illegal(cmd)) begin
                byte_addr = {addr[11:2], 2'b00};
                for (i = 0; i < 4; i++) begin
                    if (wstrb[beat][i])
                        model[byte_addr + 12'(i)] = wdata[beat][8*i +: 8];
                end
            end
            addr = next_beat_addr(addr, cmd);
            @(posedge clk);
        end
        w_valid <= 1'b0;
        w.last  <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!b_valid) begin
            count_cycle(cycles, "b_valid");
            @(negedge clk);
        end
        check_val("b.id", 32'(b.id), 32'(cmd.id));
        check_val("b.resp", 32'(b.resp), 32'(exp_resp));
        @(posedge clk);
        b_ready <= 1'b1; // B stalls for one cycle first
        @(negedge clk);
        check_val("b_valid", 32'(b_valid), 32'd1);
        @(posedge clk);
        b_ready <= 1'b0;
    endtask

    task automatic read_burst(input axi_pkg::axi_ax_t cmd, input bit back_pressure);
        axi_pkg::axi_addr_t addr;
        axi_pkg::axi_data_t exp_data;
        axi_pkg::axi_resp_e exp_resp;
        int                 cycles;
        int                 beat;
        addr     = cmd.addr;
        exp_resp = burst_illegal(cmd) ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
        @(posedge clk);
        ar_valid <= 1'b1;
        ar       <= cmd;
        cycles = 0;
        @(negedge clk);
        while (!ar_ready) begin
            count_cycle(cycles, "ar_ready");
            @(negedge clk);
        end
        @(posedge clk);
        ar_valid <= 1'b0;
        r_ready  <= 1'b1;
        beat   = 0;
        cycles = 0;
        while (beat <= int'(cmd.len)) begin
            @(negedge clk);
            if (r_valid && r_ready) begin
                exp_data = burst_illegal(cmd) ? '0 : model_word(addr);
                check_val($sformatf("r.data beat %0d", beat), r.data, exp_data);
                check_val("r.id", 32'(r.id), 32'(cmd.id));
                check_val("r.resp", 32'(r.resp), 32'(exp_resp));
                check_val("r.last", 32'(r.last), 32'(beat == int'(cmd.len)));
                addr = next_beat_addr(addr, cmd);
                beat++;
                cycles = 0;
            end else begin
                count_cycle(cycles, "an R beat");
            end
            @(posedge clk);
            r_ready <= back_pressure ? (($random(seed) & 1) != 0) : 1'b1;
        end
        r_ready <= 1'b0;
    endtask

    task automatic reset_values;
        @(negedge clk);
        check_val("aw_ready", 32'(aw_ready), 32'd1);
        check_val("ar_ready", 32'(ar_ready), 32'd1);
        check_val("b_valid", 32'(b_valid), 32'd0);
        check_val("r_valid", 32'(r_valid), 32'd0);
    endtask

    task automatic single_beat_roundtrip;
        wdata[0] = 32'hDEAD_BEEF;
        wstrb[0] = 4'hF;
        write_burst(make_cmd(4'h5, 12'h010, 8'd0, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR));
        read_burst(make_cmd(4'hA, 12'h010, 8'd0, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR), 1'b0);
    endtask

    task automatic incr_burst_stalled;
        for (int i = 0; i < 8; i++) begin
            wdata[i] = $random(seed);
            wstrb[i] = 4'hF;
        end
        write_burst(make_cmd(4'h3, 12'h100, 8'd7, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR));
        read_burst(make_cmd(4'h6, 12'h100, 8'd7, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR), 1'b1);
    endtask

    task automatic strobe_and_narrow_writes;
        wdata[0] = 32'h1122_3344;
        wstrb[0] = 4'hF;
        write_burst(make_cmd(4'h1, 12'h200, 8'd0, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR));
        wdata[0] = 32'hAABB_CCDD;
        wstrb[0] = 4'b0101; // Lanes 0 and 2
        write_burst(make_cmd(4'h2, 12'h200, 8'd0, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR));
        wdata[0] = 32'hEE00_0000;
        wstrb[0] = 4'b1000;
        write_burst(make_cmd(4'h4, 12'h203, 8'd0, axi_pkg::SIZE_1B, axi_pkg::BURST_INCR));
        read_burst(make_cmd(4'h7, 12'h200, 8'd0, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR), 1'b0);
    endtask

    task automatic wrap_and_fixed_bursts;
        for (int i = 0; i < 4; i++) begin
            wdata[i] = 32'hC0DE_0000 | 32'(i);
            wstrb[i] = 4'hF;
        end
        // Starts at the third word of the 16 byte window
        write_burst(make_cmd(4'h8, 12'h308, 8'd3, axi_pkg::SIZE_4B, axi_pkg::BURST_WRAP));
        read_burst(make_cmd(4'h9, 12'h300, 8'd3, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR), 1'b0);
        for (int i = 0; i < 4; i++)
            wdata[i] = 32'hF1F0_0000 | 32'(i);
        write_burst(make_cmd(4'hB, 12'h400, 8'd3, axi_pkg::SIZE_4B, axi_pkg::BURST_FIXED));
        read_burst(make_cmd(4'hC, 12'h400, 8'd0, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR), 1'b0);
    endtask

    task automatic illegal_bursts;
        wdata[0] = 32'h0BAD_F00D;
        wstrb[0] = 4'hF;
        write_burst(make_cmd(4'hD, 12'h010, 8'd0, axi_pkg::SIZE_8B, axi_pkg::BURST_INCR));
        read_burst(make_cmd(4'hE, 12'h010, 8'd0, axi_pkg::SIZE_4B, axi_pkg::BURST_INCR), 1'b0);
        read_burst(make_cmd(4'hF, 12'h100, 8'd2, axi_pkg::SIZE_4B, axi_pkg::BURST_WRAP), 1'b0);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        single_beat_roundtrip();
        incr_burst_stalled();
        strobe_and_narrow_writes();
        wrap_and_fixed_bursts();
        illegal_bursts();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* include/axi_ram_macros.svh */
`ifndef AXI_RAM_MACROS_SVH
`define AXI_RAM_MACROS_SVH

// Bus widths
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)
`define AXI_ADDR_W 12
`define AXI_ID_W 4
`define AXI_LEN_W 8

// Storage word address, 1024 words
`define RAM_WORD_AW 10

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -f compile.f --top-module axi_ram_tb -o axi_ram_sim
out=$(./obj_dir/axi_ram_sim) || true
echo "$out"
if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
